// File: common/pdp_mem_config.svh
/*
 * pdp_mem config
 * sizes, I/O page addresses and SRAM timing
 */
`ifndef PDP_MEM_CONFIG_SVH
`define PDP_MEM_CONFIG_SVH

// start of the I/O page in physical space
`define PDP_IOPAGE_BASE 18'o760000

// I/O page registers
`define PDP_SWR_ADDR    18'o777570
`define PDP_DISP_ADDR   18'o777572

// clocks per external SRAM access
`define PDP_SRAM_CYCLES 3

`define PDP_APB_AW      8

`endif

// File: common/pdp_mem_pkg.sv
/*
 * pdp_mem_pkg
 * shared types for the PDP-11 memory path: addresses, MMU registers, abort info
 */
package pdp_mem_pkg;

   // processor virtual byte address
   typedef logic [15:0] vaddr_t;

   // 18-bit physical byte address
   typedef logic [17:0] paddr_t;

   typedef logic [15:0] word_t;

   // page base in 64-byte blocks
   typedef logic [11:0] par_t;

   typedef enum logic [1:0] {
      ACF_NONRES = 2'd0,
      ACF_RDONLY = 2'd1,
      ACF_RDWR   = 2'd3
   } acf_e;

   typedef struct packed {
      logic [6:0] plf;
      acf_e       acf;
   } pdr_t;

   typedef struct packed {
      logic       nonres;
      logic       length;
      logic       rdonly;
      logic [2:0] page;
   } abort_t;

endpackage

// File: common/mem_bus_if.sv
/*
 * mem_bus_if
 * one physical memory cycle between the bus controller and the SRAM controller
 */
`timescale 1ns/1ps

interface mem_bus_if;
   import pdp_mem_pkg::*;

   paddr_t     addr;
   word_t      wdata;
   word_t      rdata;
   logic       rd;
   logic       wr;
   // byte enables, bit 1 is the upper lane
   logic [1:0] be;
   logic       done;

   // requester side, holds rd or wr until done
   modport ctrl (
      output addr,
      output wdata,
      output rd,
      output wr,
      output be,
      input  rdata,
      input  done
   );

   modport mem (
      input  addr,
      input  wdata,
      input  rd,
      input  wr,
      input  be,
      output rdata,
      output done
   );

endinterface

// File: mmu/mmu.sv
/*
 * mmu
 * kernel-mode PDP-11 style MMU: eight PAR/PDR pairs and MMR0 on APB,
 * 16-bit virtual to 18-bit physical relocation and abort check
 */
`timescale 1ns/1ps
`include "pdp_mem_config.svh"

module mmu (
   input  logic                    sysclk,
   input  logic                    arst_n,
   input  logic [`PDP_APB_AW-1:0]  paddr,
   input  logic                    psel,
   input  logic                    penable,
   input  logic                    pwrite,
   input  pdp_mem_pkg::word_t      pwdata,
   output pdp_mem_pkg::word_t      prdata,
   output logic                    pready,
   output logic                    pslverr,
   input  pdp_mem_pkg::vaddr_t     vaddr,
   input  logic                    wr_cycle,
   input  logic                    abort_log,
   output pdp_mem_pkg::paddr_t     phys_addr,
   output logic                    abort
);
   import pdp_mem_pkg::*;

   localparam int aw = `PDP_APB_AW;

   par_t       par [8];
   pdr_t       pdr [8];
   logic       mmu_en;
   abort_t     mmr0_abort;

   logic       acc;
   logic       sel_par;
   logic       sel_pdr;
   logic       sel_mmr0;
   logic [2:0] reg_idx;

   logic [2:0] page;
   logic [6:0] block;
   par_t       reloc;
   abort_t     reason;

   // ------------------------------------------------------------
   // APB register decode
   assign acc      = psel && penable;
   assign reg_idx  = paddr[3:1];
   assign sel_par  = (paddr[aw-1:4] == 0) && !paddr[0];
   assign sel_pdr  = (paddr[aw-1:4] == 1) && !paddr[0];
   assign sel_mmr0 = (paddr == aw'('h20));

   assign pready  = acc;
   assign pslverr = acc && !(sel_par || sel_pdr || sel_mmr0);

   always_comb
   begin
      prdata = '0;
      if (sel_par)
         prdata = {4'b0, par[reg_idx]};
      else if (sel_pdr)
         prdata = {1'b0, pdr[reg_idx].plf, 5'b0, pdr[reg_idx].acf, 1'b0};
      else if (sel_mmr0)
         prdata = {mmr0_abort.nonres, mmr0_abort.length, mmr0_abort.rdonly,
                   9'b0, mmr0_abort.page, mmu_en};
   end

   always_ff @(posedge sysclk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         for (int i = 0; i < 8; i++)
         begin
            par[i] <= '0;
            pdr[i] <= '0;
         end
         mmu_en     <= 1'b0;
         mmr0_abort <= '0;
      end
      else
      begin
         if (acc && pwrite)
         begin
            if (sel_par)
               par[reg_idx] <= pwdata[11:0];
            if (sel_pdr)
            begin
               pdr[reg_idx].plf <= pwdata[14:8];
               pdr[reg_idx].acf <= acf_e'(pwdata[2:1]);
            end
            if (sel_mmr0)
            begin
               mmu_en            <= pwdata[0];
               mmr0_abort.nonres <= pwdata[15];
               mmr0_abort.length <= pwdata[14];
               mmr0_abort.rdonly <= pwdata[13];
               mmr0_abort.page   <= pwdata[3:1];
            end
         end
         // a logged abort wins over a same-cycle MMR0 write
         if (abort_log)
            mmr0_abort <= reason;
      end
   end

   // ------------------------------------------------------------
   // relocation and abort check
   assign page  = vaddr[15:13];
   assign block = vaddr[12:6];
   assign reloc = par[page] + par_t'(block);

   always_comb
   begin
      reason.nonres = (pdr[page].acf == ACF_NONRES);
      reason.length = (block > pdr[page].plf);
      reason.rdonly = wr_cycle && (pdr[page].acf == ACF_RDONLY);
      reason.page   = page;
   end

   assign abort = mmu_en && (reason.nonres || reason.length || reason.rdonly);

   always_comb
   begin
      if (mmu_en)
         phys_addr = {reloc, vaddr[5:0]};
      else if (page == 3'b111)
         // top 8K of virtual space goes to the I/O page
         phys_addr = {2'b11, vaddr};
      else
         phys_addr = {2'b00, vaddr};
   end

endmodule

// File: verilog/bus_ctrl.sv
/*
 * bus_ctrl
 * runs one processor cycle at a time: SRAM, I/O page registers or error
 */
`timescale 1ns/1ps
`include "pdp_mem_config.svh"

module bus_ctrl (
   input  logic                 sysclk,
   input  logic                 arst_n,
   input  pdp_mem_pkg::vaddr_t  bus_addr,
   input  pdp_mem_pkg::word_t   bus_wdata,
   output pdp_mem_pkg::word_t   bus_rdata,
   input  logic                 bus_rd,
   input  logic                 bus_wr,
   input  logic                 bus_byte_op,
   output logic                 bus_ack,
   output logic                 bus_error,
   output pdp_mem_pkg::vaddr_t  vaddr,
   output logic                 wr_cycle,
   input  pdp_mem_pkg::paddr_t  paddr,
   input  logic                 abort,
   output logic                 abort_log,
   input  logic [15:0]          switches,
   output logic [7:0]           led,
   mem_bus_if.ctrl              mem
);
   import pdp_mem_pkg::*;

   localparam paddr_t iopage_base = `PDP_IOPAGE_BASE;
   localparam paddr_t swr_addr    = `PDP_SWR_ADDR;
   localparam paddr_t disp_addr   = `PDP_DISP_ADDR;

   typedef enum logic [1:0] {idle, decode, ram_wait, finish} state_e;

   state_e state;
   paddr_t pa_q;
   logic   wr_q;
   logic   byte_q;
   logic   abort_q;
   logic   sel_ram;
   logic   sel_swr;
   logic   sel_disp;
   logic   ram_req;

   assign vaddr    = bus_addr;
   assign wr_cycle = bus_wr;

   assign sel_ram  = (pa_q < iopage_base);
   assign sel_swr  = (pa_q[17:1] == swr_addr[17:1]);
   assign sel_disp = (pa_q[17:1] == disp_addr[17:1]);

   assign abort_log = (state == decode) && abort_q;

   // memory request held from decode until done
   assign ram_req   = ((state == decode) || (state == ram_wait)) && sel_ram && !abort_q;
   assign mem.rd    = ram_req && !wr_q;
   assign mem.wr    = ram_req && wr_q;
   assign mem.addr  = pa_q;
   assign mem.wdata = byte_q ? {2{bus_wdata[7:0]}} : bus_wdata;
   assign mem.be    = (!byte_q || !wr_q) ? 2'b11 : (pa_q[0] ? 2'b10 : 2'b01);

   always_ff @(posedge sysclk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         state     <= idle;
         wr_q      <= 1'b0;
         byte_q    <= 1'b0;
         abort_q   <= 1'b0;
         bus_ack   <= 1'b0;
         bus_error <= 1'b0;
         led       <= '0;
      end
      else
      begin
         case (state)
            idle:
            begin
               if (bus_rd || bus_wr)
               begin
                  wr_q    <= bus_wr;
                  byte_q  <= bus_byte_op;
                  abort_q <= abort;
                  state   <= decode;
               end
            end
            decode:
            begin
               if (abort_q || !(sel_ram || sel_swr || sel_disp))
                  bus_error <= 1'b1;
               else if (!sel_ram)
               begin
                  bus_ack <= 1'b1;
                  // led shows the low byte only
                  if (wr_q && sel_disp && (!byte_q || !pa_q[0]))
                     led <= bus_wdata[7:0];
               end
               state <= (sel_ram && !abort_q) ? ram_wait : finish;
            end
            ram_wait:
            begin
               if (mem.done)
               begin
                  bus_ack <= 1'b1;
                  state   <= finish;
               end
            end
            default:
            begin
               bus_ack   <= 1'b0;
               bus_error <= 1'b0;
               state     <= idle;
            end
         endcase
      end
   end

   always_ff @(posedge sysclk)
   begin
      if ((state == idle) && (bus_rd || bus_wr))
         pa_q <= paddr;
      if ((state == decode) && !wr_q)
      begin
         if (sel_swr)
            bus_rdata <= switches;
         else if (sel_disp)
            bus_rdata <= {8'h00, led};
      end
      if ((state == ram_wait) && mem.done)
         bus_rdata <= mem.rdata;
   end

endmodule

// File: sram/sram_ctrl.sv
/*
 * sram_ctrl
 * fixed-length cycles on a 16-bit asynchronous SRAM with byte lanes
 */
`timescale 1ns/1ps
`include "pdp_mem_config.svh"

module sram_ctrl (
   input  logic         sysclk,
   input  logic         arst_n,
   mem_bus_if.mem       mem,
   output logic [16:0]  ram_a,
   output logic         ram_ce_n,
   output logic         ram_oe_n,
   output logic         ram_we_n,
   output logic         ram_ub_n,
   output logic         ram_lb_n,
   inout  wire  [15:0]  ram_io
);
   import pdp_mem_pkg::*;

   localparam int cw = $clog2(`PDP_SRAM_CYCLES + 1);

   logic          busy;
   logic [cw-1:0] cnt;
   logic          done_q;
   logic          drive;
   logic          start;
   logic          last;
   word_t         wdata_q;
   word_t         rdata_q;

   // done_q blocks a restart while the requester still sees the old cycle
   assign start = !busy && !done_q && (mem.rd || mem.wr);
   assign last  = busy && (cnt == cw'(`PDP_SRAM_CYCLES - 1));

   assign ram_io    = drive ? wdata_q : 'z;
   assign mem.rdata = rdata_q;
   assign mem.done  = done_q;

   // ------------------------------------------------------------
   // access sequencing
   always_ff @(posedge sysclk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         busy     <= 1'b0;
         cnt      <= '0;
         done_q   <= 1'b0;
         drive    <= 1'b0;
         ram_ce_n <= 1'b1;
         ram_oe_n <= 1'b1;
         ram_we_n <= 1'b1;
         ram_ub_n <= 1'b1;
         ram_lb_n <= 1'b1;
      end
      else
      begin
         done_q <= 1'b0;
         if (start)
         begin
            busy     <= 1'b1;
            // the request cycle counts as the first clock of the access
            cnt      <= cw'(1);
            drive    <= mem.wr;
            ram_ce_n <= 1'b0;
            ram_oe_n <= !mem.rd;
            ram_we_n <= !mem.wr;
            ram_ub_n <= !mem.be[1];
            ram_lb_n <= !mem.be[0];
         end
         else if (last)
         begin
            busy     <= 1'b0;
            done_q   <= 1'b1;
            drive    <= 1'b0;
            ram_ce_n <= 1'b1;
            ram_oe_n <= 1'b1;
            ram_we_n <= 1'b1;
            ram_ub_n <= 1'b1;
            ram_lb_n <= 1'b1;
         end
         else if (busy)
            cnt <= cnt + 1'b1;
      end
   end

   // address and data, held for the whole access
   always_ff @(posedge sysclk)
   begin
      if (start)
      begin
         ram_a   <= mem.addr[17:1];
         wdata_q <= mem.wdata;
      end
      if (last && ram_we_n)
         rdata_q <= ram_io;
   end

endmodule

// File: verilog/pdp_mem_top.sv
/*
 * pdp_mem_top
 * memory side of the system: MMU, bus controller and SRAM controller
 */
`timescale 1ns/1ps
`include "pdp_mem_config.svh"

module pdp_mem_top (
   input  logic                    sysclk,
   input  logic                    arst_n,
   input  pdp_mem_pkg::vaddr_t     bus_addr,
   input  pdp_mem_pkg::word_t      bus_wdata,
   output pdp_mem_pkg::word_t      bus_rdata,
   input  logic                    bus_rd,
   input  logic                    bus_wr,
   input  logic                    bus_byte_op,
   output logic                    bus_ack,
   output logic                    bus_error,
   input  logic [`PDP_APB_AW-1:0]  paddr,
   input  logic                    psel,
   input  logic                    penable,
   input  logic                    pwrite,
   input  pdp_mem_pkg::word_t      pwdata,
   output pdp_mem_pkg::word_t      prdata,
   output logic                    pready,
   output logic                    pslverr,
   input  logic [15:0]             switches,
   output logic [7:0]              led,
   output logic [16:0]             ram_a,
   output logic                    ram_ce_n,
   output logic                    ram_oe_n,
   output logic                    ram_we_n,
   output logic                    ram_ub_n,
   output logic                    ram_lb_n,
   inout  wire  [15:0]             ram_io
);
   import pdp_mem_pkg::*;

   vaddr_t vaddr;
   paddr_t phys_addr;
   logic   wr_cycle;
   logic   abort;
   logic   abort_log;

   mem_bus_if mem_bus ();

   mmu u_mmu (
      .sysclk    (sysclk),
      .arst_n    (arst_n),
      .paddr     (paddr),
      .psel      (psel),
      .penable   (penable),
      .pwrite    (pwrite),
      .pwdata    (pwdata),
      .prdata    (prdata),
      .pready    (pready),
      .pslverr   (pslverr),
      .vaddr     (vaddr),
      .wr_cycle  (wr_cycle),
      .abort_log (abort_log),
      .phys_addr (phys_addr),
      .abort     (abort)
   );

   bus_ctrl u_bus_ctrl (
      .sysclk      (sysclk),
      .arst_n      (arst_n),
      .bus_addr    (bus_addr),
      .bus_wdata   (bus_wdata),
      .bus_rdata   (bus_rdata),
      .bus_rd      (bus_rd),
      .bus_wr      (bus_wr),
      .bus_byte_op (bus_byte_op),
      .bus_ack     (bus_ack),
      .bus_error   (bus_error),
      .vaddr       (vaddr),
      .wr_cycle    (wr_cycle),
      .paddr       (phys_addr),
      .abort       (abort),
      .abort_log   (abort_log),
      .switches    (switches),
      .led         (led),
      .mem         (mem_bus.ctrl)
   );

   sram_ctrl u_sram_ctrl (
      .sysclk   (sysclk),
      .arst_n   (arst_n),
      .mem      (mem_bus.mem),
      .ram_a    (ram_a),
      .ram_ce_n (ram_ce_n),
      .ram_oe_n (ram_oe_n),
      .ram_we_n (ram_we_n),
      .ram_ub_n (ram_ub_n),
      .ram_lb_n (ram_lb_n),
      .ram_io   (ram_io)
   );

endmodule

// File: verif/sram_model.sv
/*
 * sram_model
 * behavioral 16-bit asynchronous SRAM, 128K words, upper and lower byte enables
 */
`timescale 1ns/1ps

module sram_model (
   input  logic [16:0] ram_a,
   input  logic        ram_ce_n,
   input  logic        ram_oe_n,
   input  logic        ram_we_n,
   input  logic        ram_ub_n,
   input  logic        ram_lb_n,
   inout  wire  [15:0] ram_io
);

   logic [15:0] mem [131072];
   logic        rd_en;

   // fill pattern, every address bit takes part
   initial
   begin
      for (int i = 0; i < 131072; i++)
         mem[i] = 16'(i ^ (i >> 3)) ^ {i[16], 15'h2a5a};
   end

   assign rd_en = !ram_ce_n && !ram_oe_n && ram_we_n;

   assign ram_io[15:8] = (rd_en && !ram_ub_n) ? mem[ram_a][15:8] : 8'hzz;
   assign ram_io[7:0]  = (rd_en && !ram_lb_n) ? mem[ram_a][7:0]  : 8'hzz;

   // level-sensitive write while chip and write enable are low
   always @*
   begin
      if (!ram_ce_n && !ram_we_n)
      begin
         if (!ram_ub_n)
            mem[ram_a][15:8] = ram_io[15:8];
         if (!ram_lb_n)
            mem[ram_a][7:0] = ram_io[7:0];
      end
   end

endmodule

// File: verif/pdp_mem_assert.sv
/*
 * pdp_mem_assert
 * shadow memory and MMU registers kept from the top-level ports,
 * concurrent checks on bus responses, timing, APB reads and SRAM strobes
 */
`timescale 1ns/1ps
`include "pdp_mem_config.svh"

module pdp_mem_assert (
   input  logic                    sysclk,
   input  logic                    arst_n,
   input  pdp_mem_pkg::vaddr_t     bus_addr,
   input  pdp_mem_pkg::word_t      bus_wdata,
   input  pdp_mem_pkg::word_t      bus_rdata,
   input  logic                    bus_rd,
   input  logic                    bus_wr,
   input  logic                    bus_byte_op,
   input  logic                    bus_ack,
   input  logic                    bus_error,
   input  logic [`PDP_APB_AW-1:0]  paddr,
   input  logic                    psel,
   input  logic                    penable,
   input  logic                    pwrite,
   input  pdp_mem_pkg::word_t      pwdata,
   input  pdp_mem_pkg::word_t      prdata,
   input  logic                    pready,
   input  logic                    pslverr,
   input  logic [15:0]             switches,
   input  logic [7:0]              led,
   input  logic [16:0]             ram_a,
   input  logic                    ram_ce_n,
   input  logic                    ram_oe_n,
   input  logic                    ram_we_n,
   input  logic                    ram_ub_n,
   input  logic                    ram_lb_n
);
   import pdp_mem_pkg::*;

   logic        fail_seen = 1'b0;

   word_t       s_mem [131072];
   logic        s_vld [131072];
   logic [11:0] s_par [8];
   logic [6:0]  s_plf [8];
   logic [1:0]  s_acf [8];
   logic        s_en;
   abort_t      s_abort;

   logic        pending;
   int          cnt;
   logic        req;
   logic        resp;
   logic [2:0]  pg;
   logic [6:0]  blk;
   paddr_t      exp_pa;
   abort_t      exp_reason;
   logic        exp_abort;
   logic        exp_ram;
   logic        exp_swr;
   logic        exp_disp;
   logic        exp_err;
   int          exp_lat;
   word_t       exp_rdata;
   logic        exp_rd_valid;
   logic [1:0]  exp_lanes_n;
   logic        apb_acc;
   logic        apb_valid;
   word_t       exp_prdata;

   assign req  = bus_rd || bus_wr;
   assign resp = bus_ack || bus_error;
   assign pg   = bus_addr[15:13];
   assign blk  = bus_addr[12:6];

   // ------------------------------------------------------------
   // expected outcome of the cycle on the bus
   always_comb
   begin
      if (s_en)
         exp_pa = {s_par[pg] + 12'(blk), bus_addr[5:0]};
      else if (bus_addr >= 16'o160000)
         exp_pa = {2'b11, bus_addr};
      else
         exp_pa = {2'b00, bus_addr};
      exp_reason.nonres = (s_acf[pg] == 2'd0);
      exp_reason.length = (blk > s_plf[pg]);
      exp_reason.rdonly = bus_wr && (s_acf[pg] == 2'd1);
      exp_reason.page   = pg;
      exp_abort = s_en && (exp_reason.nonres || exp_reason.length || exp_reason.rdonly);
      exp_ram   = (exp_pa < `PDP_IOPAGE_BASE);
      exp_swr   = (exp_pa[17:1] == 17'(`PDP_SWR_ADDR >> 1));
      exp_disp  = (exp_pa[17:1] == 17'(`PDP_DISP_ADDR >> 1));
      exp_err   = exp_abort || !(exp_ram || exp_swr || exp_disp);
      exp_lat   = (exp_ram && !exp_abort) ? `PDP_SRAM_CYCLES + 2 : 2;
      if (exp_swr)
         exp_rdata = switches;
      else if (exp_disp)
         exp_rdata = {8'h00, led};
      else
         exp_rdata = s_mem[exp_pa[17:1]];
      exp_rd_valid = !exp_err && (exp_swr || exp_disp || s_vld[exp_pa[17:1]]);
      // byte writes enable only the lane picked by address bit 0
      if (bus_wr && bus_byte_op)
         exp_lanes_n = exp_pa[0] ? 2'b01 : 2'b10;
      else
         exp_lanes_n = 2'b00;
   end

   assign apb_acc   = psel && penable;
   assign apb_valid = ((paddr < 8'h20) && !paddr[0]) || (paddr == 8'h20);

   always_comb
   begin
      if (paddr == 8'h20)
         exp_prdata = {s_abort.nonres, s_abort.length, s_abort.rdonly, 9'b0,
                       s_abort.page, s_en};
      else if (paddr[4])
         exp_prdata = {1'b0, s_plf[paddr[3:1]], 5'b0, s_acf[paddr[3:1]], 1'b0};
      else
         exp_prdata = {4'b0, s_par[paddr[3:1]]};
   end

   // ------------------------------------------------------------
   // shadow state
   initial
   begin
      for (int i = 0; i < 131072; i++)
      begin
         s_mem[i] = '0;
         s_vld[i] = 1'b0;
      end
   end

   always_ff @(posedge sysclk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         pending <= 1'b0;
         cnt     <= 0;
         s_en    <= 1'b0;
         s_abort <= '0;
         for (int i = 0; i < 8; i++)
         begin
            s_par[i] <= '0;
            s_plf[i] <= '0;
            s_acf[i] <= '0;
         end
      end
      else
      begin
         if (req && !pending)
         begin
            pending <= 1'b1;
            cnt     <= 1;
         end
         else if (pending)
            cnt <= cnt + 1;
         if (resp)
         begin
            pending <= 1'b0;
            if (bus_error && exp_abort)
               s_abort <= exp_reason;
            if (bus_ack && bus_wr && exp_ram)
            begin
               if (!bus_byte_op)
               begin
                  s_mem[exp_pa[17:1]] <= bus_wdata;
                  s_vld[exp_pa[17:1]] <= 1'b1;
               end
               else if (exp_pa[0])
                  s_mem[exp_pa[17:1]][15:8] <= bus_wdata[7:0];
               else
                  s_mem[exp_pa[17:1]][7:0] <= bus_wdata[7:0];
            end
         end
         if (apb_acc && pwrite && apb_valid)
         begin
            if (paddr == 8'h20)
            begin
               s_en    <= pwdata[0];
               s_abort <= {pwdata[15:13], pwdata[3:1]};
            end
            else if (paddr[4])
            begin
               s_plf[paddr[3:1]] <= pwdata[14:8];
               s_acf[paddr[3:1]] <= pwdata[2:1];
            end
            else
               s_par[paddr[3:1]] <= pwdata[11:0];
         end
      end
   end

   // ------------------------------------------------------------
   // checks
   a_one_resp: assert property (@(posedge sysclk) disable iff (!arst_n)
      resp |-> pending && !(bus_ack && bus_error))
      else
      begin
         $error("[FAIL] bus_ack/bus_error got %h/%h with no open request",
                bus_ack, bus_error);
         fail_seen = 1'b1;
      end

   a_req_held: assert property (@(posedge sysclk) disable iff (!arst_n)
      pending |-> req)
      else
      begin
         $error("request dropped before it was answered");
         fail_seen = 1'b1;
      end

   a_kind: assert property (@(posedge sysclk) disable iff (!arst_n)
      resp |-> (bus_error == exp_err))
      else
      begin
         $error("[FAIL] bus_error got %h expected %h", bus_error, exp_err);
         fail_seen = 1'b1;
      end

   a_latency: assert property (@(posedge sysclk) disable iff (!arst_n)
      resp |-> (cnt == exp_lat))
      else
      begin
         $error("[FAIL] cycle length got %h expected %h", cnt, exp_lat);
         fail_seen = 1'b1;
      end

   a_rdata: assert property (@(posedge sysclk) disable iff (!arst_n)
      (bus_ack && bus_rd && exp_rd_valid) |-> (bus_rdata == exp_rdata))
      else
      begin
         $error("[FAIL] bus_rdata got %h expected %h", bus_rdata, exp_rdata);
         fail_seen = 1'b1;
      end

   a_led: assert property (@(posedge sysclk) disable iff (!arst_n)
      (bus_ack && bus_wr && exp_disp && !(bus_byte_op && bus_addr[0]))
      |-> (led == bus_wdata[7:0]))
      else
      begin
         $error("[FAIL] led got %h expected %h", led, bus_wdata[7:0]);
         fail_seen = 1'b1;
      end

   a_we_quiet: assert property (@(posedge sysclk) disable iff (!arst_n)
      resp |-> ram_we_n)
      else
      begin
         $error("SRAM write enable is low during a bus response");
         fail_seen = 1'b1;
      end

   // SRAM is only selected inside an open RAM cycle that was not aborted
   a_sram_idle: assert property (@(posedge sysclk) disable iff (!arst_n)
      !ram_ce_n |-> (pending && exp_ram && !exp_abort))
      else
      begin
         $error("SRAM selected outside a RAM cycle or during an aborted cycle");
         fail_seen = 1'b1;
      end

   a_sram_addr: assert property (@(posedge sysclk) disable iff (!arst_n)
      !ram_ce_n |-> (ram_a == exp_pa[17:1]))
      else
      begin
         $error("[FAIL] ram_a got %h expected %h", ram_a, exp_pa[17:1]);
         fail_seen = 1'b1;
      end

   a_sram_strobes: assert property (@(posedge sysclk) disable iff (!arst_n)
      !ram_ce_n |-> ({ram_we_n, ram_oe_n, ram_ub_n, ram_lb_n}
                     == {!bus_wr, bus_wr, exp_lanes_n}))
      else
      begin
         $error("[FAIL] ram_we_n,ram_oe_n,ram_ub_n,ram_lb_n got %h expected %h",
                {ram_we_n, ram_oe_n, ram_ub_n, ram_lb_n},
                {!bus_wr, bus_wr, exp_lanes_n});
         fail_seen = 1'b1;
      end

   a_apb_err: assert property (@(posedge sysclk) disable iff (!arst_n)
      apb_acc |-> (pready && (pslverr == !apb_valid)))
      else
      begin
         $error("[FAIL] pslverr got %h expected %h", pslverr, !apb_valid);
         fail_seen = 1'b1;
      end

   a_apb_rd: assert property (@(posedge sysclk) disable iff (!arst_n)
      (apb_acc && !pwrite && apb_valid) |-> (prdata == exp_prdata))
      else
      begin
         $error("[FAIL] prdata got %h expected %h", prdata, exp_prdata);
         fail_seen = 1'b1;
      end

endmodule

bind pdp_mem_top pdp_mem_assert chk (.*);

// File: verif/tb_pdp_mem.sv
/*
 * tb_pdp_mem
 * drives the processor bus and APB of pdp_mem_top; bound assertions check
 */
`timescale 1ns/1ps
`include "pdp_mem_config.svh"

module tb_pdp_mem;
   import pdp_mem_pkg::*;

   localparam int timeout_cycles = 20000;

   logic        sysclk = 1'b0;
   logic        arst_n = 1'b0;
   vaddr_t      bus_addr = '0;
   word_t       bus_wdata = '0;
   word_t       bus_rdata;
   logic        bus_rd = 1'b0;
   logic        bus_wr = 1'b0;
   logic        bus_byte_op = 1'b0;
   logic        bus_ack;
   logic        bus_error;
   logic [7:0]  paddr = '0;
   logic        psel = 1'b0;
   logic        penable = 1'b0;
   logic        pwrite = 1'b0;
   word_t       pwdata = '0;
   word_t       prdata;
   logic        pready;
   logic        pslverr;
   logic [15:0] switches = 16'h0000;
   logic [7:0]  led;
   logic [16:0] ram_a;
   logic        ram_ce_n;
   logic        ram_oe_n;
   logic        ram_we_n;
   logic        ram_ub_n;
   logic        ram_lb_n;
   wire  [15:0] ram_io;

   logic [31:0] rng_state = 32'd18391;
   int          cycles = 0;
   vaddr_t      addrs [16];

   always #4 sysclk = !sysclk;

   pdp_mem_top uut (.*);

   sram_model u_sram (
      .ram_a    (ram_a),
      .ram_ce_n (ram_ce_n),
      .ram_oe_n (ram_oe_n),
      .ram_we_n (ram_we_n),
      .ram_ub_n (ram_ub_n),
      .ram_lb_n (ram_lb_n),
      .ram_io   (ram_io)
   );

   // ------------------------------------------------------------
   // run limit and failure watch
   always @(posedge sysclk)
   begin
      cycles <= cycles + 1;
      if (cycles >= timeout_cycles)
      begin
         $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
         $display("Done: errors found");
         $fatal(1);
      end
   end

   always @(posedge sysclk)
   begin
      if (uut.chk.fail_seen)
      begin
         $display("Done: errors found");
         $fatal(1);
      end
   end

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   function automatic word_t pdr_word(input logic [6:0] plf, input logic [1:0] acf);
      return {1'b0, plf, 5'b0, acf, 1'b0};
   endfunction

   // one processor cycle, held until ack or error, then one idle cycle
   task automatic bus_cycle(input vaddr_t addr, input word_t data, input logic wr,
                            input logic byte_op);
      @(posedge sysclk);
      bus_addr    <= addr;
      bus_wdata   <= data;
      bus_rd      <= !wr;
      bus_wr      <= wr;
      bus_byte_op <= byte_op;
      do
         @(posedge sysclk);
      while (!(bus_ack || bus_error));
      bus_rd <= 1'b0;
      bus_wr <= 1'b0;
      @(posedge sysclk);
   endtask

   task automatic apb_access(input logic [7:0] addr, input logic wr, input word_t data);
      @(posedge sysclk);
      paddr   <= addr;
      pwrite  <= wr;
      pwdata  <= data;
      psel    <= 1'b1;
      penable <= 1'b0;
      @(posedge sysclk);
      penable <= 1'b1;
      @(posedge sysclk);
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   task automatic map_page(input int n, input logic [11:0] par, input word_t pdr);
      apb_access(8'(2 * n), 1'b1, {4'b0, par});
      apb_access(8'(8'h10 + 2 * n), 1'b1, pdr);
      apb_access(8'(2 * n), 1'b0, '0);
      apb_access(8'(8'h10 + 2 * n), 1'b0, '0);
   endtask

   initial
   begin
      repeat (4) @(posedge sysclk);
      arst_n <= 1'b1;
      @(posedge sysclk);

      // word writes and reads, MMU off
      for (int i = 0; i < 16; i++)
      begin
         rng_state = lcg_next(rng_state);
         addrs[i] = 16'(rng_state[31:16] % 16'o160000) & 16'hfffe;
         rng_state = lcg_next(rng_state);
         bus_cycle(addrs[i], rng_state[31:16], 1'b1, 1'b0);
      end
      for (int i = 0; i < 16; i++)
         bus_cycle(addrs[i], '0, 1'b0, 1'b0);

      // byte lanes
      bus_cycle(addrs[0] | 16'h1, 16'h00c3, 1'b1, 1'b1);
      bus_cycle(addrs[1], 16'h003c, 1'b1, 1'b1);
      bus_cycle(addrs[0], '0, 1'b0, 1'b0);
      bus_cycle(addrs[1], '0, 1'b0, 1'b0);

      // I/O page
      rng_state = lcg_next(rng_state);
      switches <= rng_state[31:16];
      bus_cycle(16'o177570, '0, 1'b0, 1'b0);
      bus_cycle(16'o177572, 16'h00a5, 1'b1, 1'b1);
      bus_cycle(16'o177572, '0, 1'b0, 1'b0);
      bus_cycle(16'o177500, '0, 1'b0, 1'b0);

      // ------------------------------------------------------------
      // MMU registers and relocation
      map_page(0, 12'o0000, pdr_word(7'd127, 2'd3));
      map_page(1, 12'o0400, pdr_word(7'd127, 2'd3));
      map_page(2, 12'o0400, pdr_word(7'd127, 2'd3));
      map_page(3, 12'o1000, pdr_word(7'd3, 2'd3));
      map_page(4, 12'o1200, pdr_word(7'd127, 2'd0));
      map_page(5, 12'o0400, pdr_word(7'd127, 2'd1));
      apb_access(8'h30, 1'b0, '0);
      apb_access(8'h20, 1'b1, 16'h0001);
      apb_access(8'h20, 1'b0, '0);
      bus_cycle(16'o021234, 16'h1357, 1'b1, 1'b0);
      bus_cycle(16'o041234, '0, 1'b0, 1'b0);

      // aborts: length, nonresident, read-only
      bus_cycle(16'o060500, 16'hdead, 1'b1, 1'b0);
      apb_access(8'h20, 1'b0, '0);
      bus_cycle(16'o100010, 16'hbeef, 1'b1, 1'b0);
      apb_access(8'h20, 1'b0, '0);
      bus_cycle(16'o121234, 16'h2468, 1'b1, 1'b0);
      apb_access(8'h20, 1'b0, '0);
      bus_cycle(16'o121234, '0, 1'b0, 1'b0);
      bus_cycle(16'o041234, '0, 1'b0, 1'b0);

      repeat (4) @(posedge sysclk);
      if (uut.chk.fail_seen)
      begin
         $display("Done: errors found");
         $fatal(1);
      end
      else
      begin
         $display("Done: no errors");
         $finish;
      end
   end

endmodule

// File: build.f
+incdir+common
common/pdp_mem_pkg.sv
common/mem_bus_if.sv
mmu/mmu.sv
verilog/bus_ctrl.sv
sram/sram_ctrl.sv
verilog/pdp_mem_top.sv
verif/sram_model.sv
verif/pdp_mem_assert.sv
verif/tb_pdp_mem.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert --timing
TOP       ?= tb_pdp_mem
FILELIST  ?= build.f
RUNFLAGS  ?= +verilator+error+limit+100

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP) $(RUNFLAGS) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "Done: no errors"

clean:
	rm -rf obj_dir
